//--- rtl/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// Cache geometry.
`define CACHE_BLOCK_WORDS 8  // Words in one 16-byte block.
`define CACHE_SETS 32        // Sets in each cache.

// Main memory.
`define MEMORY_WORDS 32768   // Depth in 16-bit words, covering the 64 KB space.
`define MEMORY_LATENCY 4     // Cycles from an enabled address to its data.

`endif

//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // Byte address as a cache reads it.
  typedef struct packed {
    logic [5:0] tag;         // Upper bits compared against the stored tag.
    logic [4:0] set;         // Selects one of the sets.
    logic [2:0] word;        // Word within the 16-byte block.
    logic       byte_select; // Always zero for word accesses.
  } address_t;

  // One tag array entry, packed like the tag word of the fill FSM.
  typedef struct packed {
    logic [5:0] tag;   // Stored tag.
    logic       valid; // Block holds real data.
    logic       lru;   // Set when this way is the least recently used.
  } tag_entry_t;

  // Lookup request from a processor port.
  typedef struct packed {
    logic     valid;   // Single-cycle request strobe.
    address_t address; // Held steady while the cache is busy.
  } cache_request_t;

  // Answer to the processor port.
  typedef struct packed {
    logic        hit;  // Data is valid this cycle.
    logic        busy; // A miss fill is in progress.
    logic [15:0] data; // Word read from the hitting way.
  } cache_response_t;

  // Request into the shared main memory.
  typedef struct packed {
    logic        enable;  // One word address per cycle.
    logic [15:0] address; // Byte address of the word.
  } memory_request_t;

  // Word coming back from main memory.
  typedef struct packed {
    logic        valid; // Pulses once per returned word.
    logic [15:0] data;  // Returned word.
  } memory_return_t;

  // Array writes from the fill FSM.
  typedef struct packed {
    logic        data_write; // Write one word into the data array.
    logic        tag_write;  // Write the tag entry after the last word.
    logic        way;        // Victim way being refilled.
    address_t    address;    // Cache address of the word being written.
    tag_entry_t  tag;        // New tag entry for the refilled way.
    logic [15:0] data;       // Word taken from the memory return.
  } fill_write_t;

endpackage

`default_nettype wire

//--- rtl/cache_fill_control.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_fill_control (
  input  wire                         clk,
  input  wire                         reset,
  input  wire cache_pkg::cache_request_t request,    // Port request, holds the miss address.
  input  wire                         miss,          // Strobe without a hit while idle.
  input  wire                         victim_way,    // Way chosen by the arrays at the miss.
  input  wire                         proceed,       // Grant from the memory arbiter.
  input  wire cache_pkg::memory_return_t memory,     // Routed memory return.
  output logic                        busy,          // High from the miss edge to the last word.
  output cache_pkg::memory_request_t  memory_request,
  output cache_pkg::fill_write_t      fill
);

  typedef enum logic [1:0] {
    IDLE = 2'h0, // Waiting for a miss.
    WAIT = 2'h1, // Waiting for the memory grant.
    SEND = 2'h2  // Sending addresses and filling the block.
  } state_t;

  state_t      state;
  state_t      next_state;
  logic        mem_en;                               // Address to memory is valid.
  logic [15:0] fill_address;                         // Next word address sent to memory.
  logic [15:0] delay_address [0:`MEMORY_LATENCY-1];  // Fill address aligned to the return.
  logic [2:0]  word_count;                           // Words already returned.
  logic        fill_way;                             // Victim captured at the miss.
  logic [5:0]  fill_tag;                             // Tag captured at the miss.
  logic        start_miss;
  logic        last_address;
  logic        last_word;

  assign start_miss   = (state == IDLE) && miss;
  assign last_address = mem_en && (fill_address[3:1] == 3'(`CACHE_BLOCK_WORDS - 1));
  assign last_word    = memory.valid && (word_count == 3'(`CACHE_BLOCK_WORDS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Next state logic. An unknown encoding recovers to IDLE.
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    next_state = state; // Stay put unless an event moves us.
    case (state)
      IDLE    : if (miss) next_state = WAIT;
      WAIT    : if (proceed) next_state = SEND;
      SEND    : if (last_word) next_state = IDLE;
      default : next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= IDLE;
      busy       <= 1'b0;
      mem_en     <= 1'b0;
      word_count <= 3'h0;
    end else begin
      state <= next_state;
      busy  <= (next_state != IDLE); // Rises at the miss edge, falls with the tag write.
      // Set on the grant edge, cleared once the eighth address is out.
      mem_en <= ((state == WAIT) && proceed) || (mem_en && !last_address);
      if (start_miss)
        word_count <= 3'h0;
      else if ((state == SEND) && memory.valid)
        word_count <= word_count + 3'h1; // Wraps back to zero on the last word.
    end
  end

  // Block base capture, address stepping and the latency delay line.
  always_ff @(posedge clk) begin
    if (start_miss) begin
      fill_address <= {1'b0, request.address.tag, request.address.set, 4'h0}; // Block base.
      fill_way     <= victim_way;
      fill_tag     <= request.address.tag;
    end else if (mem_en) begin
      fill_address <= fill_address + 16'h0002; // One word per cycle.
    end
    delay_address[0] <= fill_address; // Same edge that registers the memory request.
    for (int i = 1; i < `MEMORY_LATENCY; i++) begin
      delay_address[i] <= delay_address[i-1];
    end
  end

  assign memory_request.enable  = mem_en;
  assign memory_request.address = fill_address;

  // Each returned word lands at the address sent four cycles earlier.
  assign fill.data_write = (state == SEND) && memory.valid;
  assign fill.tag_write  = (state == SEND) && last_word;
  assign fill.way        = fill_way;
  assign fill.address    = delay_address[`MEMORY_LATENCY-1][14:0];
  assign fill.tag        = '{tag: fill_tag, valid: 1'b1, lru: 1'b0}; // Newest way is MRU.
  assign fill.data       = memory.data;

endmodule

`default_nettype wire

//--- rtl/cache_way_arrays.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module cache_way_arrays (
  input  wire                      clk,
  input  wire                      reset,
  input  wire cache_pkg::address_t lookup_address, // Address of the port request.
  input  wire cache_pkg::fill_write_t fill,        // Writes from the fill FSM.
  input  wire                      access_strobe,  // Qualified request, updates LRU on a hit.
  output logic                     hit,
  output logic [15:0]              read_data,
  output logic                     victim_way      // Way to refill on a miss.
);

  localparam int ENTRIES = `CACHE_SETS * `CACHE_BLOCK_WORDS;

  cache_pkg::tag_entry_t tag_way  [0:1][0:`CACHE_SETS-1];
  logic [15:0]           data_way [0:1][0:ENTRIES-1];
  cache_pkg::tag_entry_t tag_0;      // Way 0 entry of the looked up set.
  cache_pkg::tag_entry_t tag_1;      // Way 1 entry of the looked up set.
  logic                  hit_0;
  logic                  hit_1;
  logic [7:0]            read_index; // Set and word of the lookup.
  logic [7:0]            fill_index; // Set and word of the fill write.

  assign tag_0      = tag_way[0][lookup_address.set];
  assign tag_1      = tag_way[1][lookup_address.set];
  assign read_index = {lookup_address.set, lookup_address.word};
  assign fill_index = {fill.address.set, fill.address.word};

  // Both ways are compared in parallel.
  assign hit_0 = tag_0.valid && (tag_0.tag == lookup_address.tag);
  assign hit_1 = tag_1.valid && (tag_1.tag == lookup_address.tag);
  assign hit   = hit_0 || hit_1;

  assign read_data = hit_1 ? data_way[1][read_index] : data_way[0][read_index];

  // An empty way is refilled before the least recently used one.
  assign victim_way = !tag_0.valid ? 1'b0 : (!tag_1.valid ? 1'b1 : tag_1.lru);

  ////////////////////////////////////////////////////////////////////////////
  // Tag arrays. Reset clears every valid bit.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int s = 0; s < `CACHE_SETS; s++) begin
        tag_way[0][s] <= '0;
        tag_way[1][s] <= '0;
      end
    end else if (fill.tag_write) begin
      tag_way[fill.way][fill.address.set]      <= fill.tag;
      tag_way[~fill.way][fill.address.set].lru <= 1'b1; // The other way ages.
    end else if (access_strobe && hit) begin
      // The hitting way becomes most recent and its partner the victim.
      tag_way[0][lookup_address.set].lru <= hit_1;
      tag_way[1][lookup_address.set].lru <= hit_0;
    end
  end

  // Data arrays take one word per memory return.
  always_ff @(posedge clk) begin
    if (fill.data_write)
      data_way[fill.way][fill_index] <= fill.data;
  end

endmodule

`default_nettype wire

//--- rtl/cache_unit.sv
`timescale 1ns/10ps
`default_nettype none

module cache_unit (
  input  wire                            clk,
  input  wire                            reset,
  input  wire cache_pkg::cache_request_t request,
  output cache_pkg::cache_response_t     response,
  output cache_pkg::memory_request_t     memory_request, // To the memory arbiter.
  input  wire                            proceed,        // Grant from the arbiter.
  input  wire cache_pkg::memory_return_t memory
);

  logic                   hit;
  logic                   busy;
  logic                   miss;
  logic                   access_strobe;
  logic                   victim_way;
  logic [15:0]            read_data;
  cache_pkg::fill_write_t fill;

  assign access_strobe = request.valid && !busy;  // Lookups count only while idle.
  assign miss          = access_strobe && !hit;   // Starts a fill on the next edge.

  // A hit is hidden while a fill is rewriting the arrays.
  assign response.hit  = hit && !busy;
  assign response.busy = busy;
  assign response.data = read_data;

  cache_way_arrays arrays_i (
    .clk            (clk),
    .reset          (reset),
    .lookup_address (request.address),
    .fill           (fill),
    .access_strobe  (access_strobe),
    .hit            (hit),
    .read_data      (read_data),
    .victim_way     (victim_way)
  );

  cache_fill_control fill_control_i (
    .clk            (clk),
    .reset          (reset),
    .request        (request),
    .miss           (miss),
    .victim_way     (victim_way),
    .proceed        (proceed),
    .memory         (memory),
    .busy           (busy),
    .memory_request (memory_request),
    .fill           (fill)
  );

endmodule

`default_nettype wire

//--- rtl/memory_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module memory_arbiter (
  input  wire                             clk,
  input  wire                             reset,
  input  wire cache_pkg::memory_request_t instruction_request,
  input  wire cache_pkg::memory_request_t data_request,
  input  wire                             instruction_busy, // A fill is waiting or running.
  input  wire                             data_busy,
  output logic                            instruction_grant,
  output logic                            data_grant,
  output cache_pkg::memory_request_t      memory_request,   // To main memory.
  input  wire cache_pkg::memory_return_t  memory,           // From main memory.
  output cache_pkg::memory_return_t       instruction_return,
  output cache_pkg::memory_return_t       data_return
);

  logic owner_valid; // Some cache owns the memory.
  logic owner_data;  // The owner is the data cache.
  logic owner_busy;

  assign owner_busy = owner_data ? data_busy : instruction_busy;

  ////////////////////////////////////////////////////////////////////////////
  // Ownership is taken while free and held until the owner's busy falls.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      owner_valid <= 1'b0;
      owner_data  <= 1'b0;
    end else if (owner_valid) begin
      if (!owner_busy)
        owner_valid <= 1'b0; // Fill finished, memory is free next cycle.
    end else if (data_busy) begin
      owner_valid <= 1'b1;   // Data cache wins a tie.
      owner_data  <= 1'b1;
    end else if (instruction_busy) begin
      owner_valid <= 1'b1;
      owner_data  <= 1'b0;
    end
  end

  assign data_grant        = owner_valid && owner_data;
  assign instruction_grant = owner_valid && !owner_data;

  // Only the owner reaches memory.
  assign memory_request = data_grant        ? data_request        :
                          instruction_grant ? instruction_request : '0;

  // Returned words go to the owner alone.
  assign data_return.valid        = memory.valid && data_grant;
  assign data_return.data         = memory.data;
  assign instruction_return.valid = memory.valid && instruction_grant;
  assign instruction_return.data  = memory.data;

endmodule

`default_nettype wire

//--- rtl/main_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module main_memory (
  input  wire                             clk,
  input  wire                             reset,
  input  wire cache_pkg::memory_request_t request,      // One address per cycle.
  input  wire                             load_valid,   // Boot loader write strobe.
  input  wire [15:0]                      load_address, // Byte address of the loaded word.
  input  wire [15:0]                      load_data,
  output cache_pkg::memory_return_t       response
);

  logic [15:0]                memory_words [0:`MEMORY_WORDS-1];
  cache_pkg::memory_request_t pipe [0:`MEMORY_LATENCY-1]; // Address and valid in flight.

  // Loader writes land straight in the array.
  always_ff @(posedge clk) begin
    if (load_valid)
      memory_words[load_address[15:1]] <= load_data;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read pipeline. Only the enable bits are cleared by reset.
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    pipe[0] <= request;
    for (int i = 1; i < `MEMORY_LATENCY; i++) begin
      pipe[i] <= pipe[i-1];
    end
    if (reset) begin
      for (int i = 0; i < `MEMORY_LATENCY; i++) begin
        pipe[i].enable <= 1'b0;
      end
    end
  end

  // The array is read at the last stage.
  assign response.valid = pipe[`MEMORY_LATENCY-1].enable;
  assign response.data  = memory_words[pipe[`MEMORY_LATENCY-1].address[15:1]];

endmodule

`default_nettype wire

//--- rtl/memory_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module memory_subsystem (
  input  wire                            clk,
  input  wire                            reset,
  input  wire cache_pkg::cache_request_t instruction_request,
  output cache_pkg::cache_response_t     instruction_response,
  input  wire cache_pkg::cache_request_t data_request,
  output cache_pkg::cache_response_t     data_response,
  input  wire                            load_valid,
  input  wire [15:0]                     load_address,
  input  wire [15:0]                     load_data
);

  cache_pkg::memory_request_t instruction_memory_request; // Instruction cache fill requests.
  cache_pkg::memory_request_t data_memory_request;        // Data cache fill requests.
  cache_pkg::memory_request_t memory_request;             // Granted request to memory.
  cache_pkg::memory_return_t  memory_return;              // Raw memory return.
  cache_pkg::memory_return_t  instruction_return;
  cache_pkg::memory_return_t  data_return;
  logic                       instruction_grant;
  logic                       data_grant;

  cache_unit instruction_cache_i (
    .clk (clk), .reset (reset),
    .request        (instruction_request),
    .response       (instruction_response),
    .memory_request (instruction_memory_request),
    .proceed        (instruction_grant),
    .memory         (instruction_return)
  );

  cache_unit data_cache_i (
    .clk (clk), .reset (reset),
    .request        (data_request),
    .response       (data_response),
    .memory_request (data_memory_request),
    .proceed        (data_grant),
    .memory         (data_return)
  );

  memory_arbiter memory_arbiter_i (
    .clk (clk), .reset (reset),
    .instruction_request (instruction_memory_request),
    .data_request        (data_memory_request),
    .instruction_busy    (instruction_response.busy),
    .data_busy           (data_response.busy),
    .instruction_grant   (instruction_grant),
    .data_grant          (data_grant),
    .memory_request      (memory_request),
    .memory              (memory_return),
    .instruction_return  (instruction_return),
    .data_return         (data_return)
  );

  main_memory main_memory_i (
    .clk (clk), .reset (reset),
    .request      (memory_request),
    .load_valid   (load_valid),
    .load_address (load_address),
    .load_data    (load_data),
    .response     (memory_return)
  );

endmodule

`default_nettype wire

//--- test/memory_subsystem_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "cache_settings.svh"

module memory_subsystem_assertions (
  input wire                             clk,
  input wire                             reset,
  input wire                             busy,           // Fill in progress.
  input wire                             miss,           // Strobe without a hit while idle.
  input wire                             proceed,        // Grant from the arbiter.
  input wire cache_pkg::memory_request_t memory_request, // Addresses sent to memory.
  input wire cache_pkg::fill_write_t     fill            // Writes into the arrays.
);

  logic [3:0] enable_count; // Addresses sent during the current fill.
  logic [3:0] write_count;  // Words written during the current fill.

  // Both counters restart at every miss.
  always_ff @(posedge clk) begin
    if (reset || miss) begin
      enable_count <= 4'h0;
      write_count  <= 4'h0;
    end else begin
      if (memory_request.enable)
        enable_count <= enable_count + 4'h1;
      if (fill.data_write)
        write_count <= write_count + 4'h1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fill FSM rules.
  ////////////////////////////////////////////////////////////////////////////
  reset_idle: assert property (@(posedge clk) reset |=> !busy && !memory_request.enable)
    else $error("busy or mem_en high after reset");
  enable_needs_grant: assert property (@(posedge clk) disable iff (reset)
    memory_request.enable |-> proceed) else $error("mem_en high without the grant");
  enable_inside_fill: assert property (@(posedge clk) disable iff (reset)
    memory_request.enable |-> busy) else $error("mem_en high while idle");
  write_follows_address: assert property (@(posedge clk) disable iff (reset)
    memory_request.enable |-> ##(`MEMORY_LATENCY) fill.data_write)
    else $error("returned word not written at the memory latency");
  eight_words: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |-> (enable_count == 4'd8) && (write_count == 4'd8))
    else $error("fill did not send and write exactly eight words");
  grant_released: assert property (@(posedge clk) disable iff (reset)
    $fell(busy) |=> !proceed) else $error("grant held after the fill ended");

endmodule

`default_nettype wire

//--- test/memory_subsystem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module memory_subsystem_tb;

  localparam int LOADED_WORDS = 2048; // Byte addresses 0 to 0x0FFE, tags 0 to 7.
  localparam int BUSY_TIMEOUT = 100;  // Cycles allowed for any single wait.

  logic                       clk;
  logic                       reset;
  cache_pkg::cache_request_t  instruction_request;
  cache_pkg::cache_request_t  data_request;
  cache_pkg::cache_response_t instruction_response;
  cache_pkg::cache_response_t data_response;
  logic                       load_valid;
  logic [15:0]                load_address;
  logic [15:0]                load_data;
  logic [15:0]                model_words [0:LOADED_WORDS-1]; // What the loader wrote.
  integer                     seed = 32'h0b569689;
  int                         check_count = 0;
  int                         error_count = 0;

  memory_subsystem memory_subsystem_i (
    .clk                  (clk),
    .reset                (reset),
    .instruction_request  (instruction_request),
    .instruction_response (instruction_response),
    .data_request         (data_request),
    .data_response        (data_response),
    .load_valid           (load_valid),
    .load_address         (load_address),
    .load_data            (load_data)
  );

  // Every fill FSM in the design gets its own checker.
  bind cache_fill_control memory_subsystem_assertions fill_assertions_i (
    .clk (clk), .reset (reset), .busy (busy), .miss (miss), .proceed (proceed),
    .memory_request (memory_request), .fill (fill)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period.
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers for addresses, ports and the memory model.
  ////////////////////////////////////////////////////////////////////////////
  function automatic cache_pkg::address_t block_address(input logic [5:0] tag_bits,
      input logic [4:0] set_bits, input logic [2:0] word_bits);
    cache_pkg::address_t address;
    address.tag         = tag_bits;
    address.set         = set_bits;
    address.word        = word_bits;
    address.byte_select = 1'b0; // Word accesses only.
    return address;
  endfunction

  // Word index in memory is the byte address without its byte bit.
  function automatic logic [15:0] expected_word(input cache_pkg::address_t address);
    return model_words[int'({address.tag, address.set, address.word})];
  endfunction

  function automatic cache_pkg::cache_response_t port_response(input bit is_data);
    return is_data ? data_response : instruction_response;
  endfunction

  function automatic string port_name(input bit is_data);
    return is_data ? "data_response" : "instruction_response";
  endfunction

  task automatic drive_port(input bit is_data, input logic valid,
      input cache_pkg::address_t address);
    if (is_data) begin
      data_request.valid   = valid;
      data_request.address = address;
    end else begin
      instruction_request.valid   = valid;
      instruction_request.address = address;
    end
  endtask

  // Boot loader fills the low memory with random words and keeps a copy.
  task automatic load_memory();
    logic [15:0] word;
    for (int i = 0; i < LOADED_WORDS; i++) begin
      word = 16'($random(seed));
      @(posedge clk);
      #2;
      load_valid     = 1'b1;
      load_address   = 16'(i * 2);
      load_data      = word;
      model_words[i] = word;
    end
    @(posedge clk);
    #2;
    load_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks, one per kind of result.
  ////////////////////////////////////////////////////////////////////////////
  task automatic compare_hit(input string signal, input cache_pkg::cache_response_t response,
      input logic expected);
    check_count++;
    if (response.hit !== expected) begin
      error_count++;
      $display("FAILED %s.hit expected %h got %h", signal, expected, response.hit);
    end
  endtask

  task automatic compare_busy(input string signal, input cache_pkg::cache_response_t response,
      input logic expected);
    check_count++;
    if (response.busy !== expected) begin
      error_count++;
      $display("FAILED %s.busy expected %h got %h", signal, expected, response.busy);
    end
  endtask

  task automatic compare_data(input string signal, input cache_pkg::cache_response_t response,
      input logic [15:0] expected);
    check_count++;
    if (response.data !== expected) begin
      error_count++;
      $display("FAILED %s.data expected %h got %h", signal, expected, response.data);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Port sequences. Inputs change 2 ns after a rising edge, outputs are
  // sampled on the falling edge.
  ////////////////////////////////////////////////////////////////////////////
  task automatic read_port(input bit is_data, input cache_pkg::address_t address,
      output cache_pkg::cache_response_t response);
    @(posedge clk);
    #2;
    drive_port(is_data, 1'b1, address); // One-cycle strobe.
    @(negedge clk);
    response = port_response(is_data);
    @(posedge clk);
    #2;
    drive_port(is_data, 1'b0, address); // Address stays put while busy.
  endtask

  task automatic wait_idle(input bit is_data);
    int                         cycles;
    cache_pkg::cache_response_t response;
    cycles = 0;
    @(negedge clk);
    response = port_response(is_data);
    while (response.busy && (cycles < BUSY_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
      response = port_response(is_data);
    end
    if (response.busy) begin
      error_count++;
      $display("%s busy did not fall within %0d cycles", port_name(is_data), BUSY_TIMEOUT);
    end
  endtask

  task automatic check_miss_read(input bit is_data, input cache_pkg::address_t address);
    cache_pkg::cache_response_t response;
    read_port(is_data, address, response);
    compare_hit(port_name(is_data), response, 1'b0);
    @(negedge clk);
    compare_busy(port_name(is_data), port_response(is_data), 1'b1); // Set by the miss edge.
    wait_idle(is_data);
  endtask

  task automatic check_hit_read(input bit is_data, input cache_pkg::address_t address);
    cache_pkg::cache_response_t response;
    read_port(is_data, address, response);
    compare_hit(port_name(is_data), response, 1'b1);
    compare_busy(port_name(is_data), response, 1'b0);
    compare_data(port_name(is_data), response, expected_word(address));
  endtask

  task automatic report_test(input int number, input string name, input int errors_before);
    if (error_count == errors_before)
      $display("test %0d %s: no errors", number, name);
    else
      $display("test %0d %s: %0d errors", number, name, error_count - errors_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests.
  ////////////////////////////////////////////////////////////////////////////
  task automatic cold_miss_test();
    int errors_before;
    errors_before = error_count;
    check_miss_read(1'b1, block_address(6'd0, 5'd3, 3'd5));
    check_hit_read(1'b1, block_address(6'd0, 5'd3, 3'd5));
    report_test(1, "cold miss then hit", errors_before);
  endtask

  task automatic whole_block_test();
    int errors_before;
    errors_before = error_count;
    check_miss_read(1'b1, block_address(6'd0, 5'd4, 3'd0));
    for (int w = 0; w < 8; w++)
      check_hit_read(1'b1, block_address(6'd0, 5'd4, 3'(w))); // Busy must stay low.
    @(negedge clk);
    compare_busy("data_response", data_response, 1'b0); // The last hit started no fill.
    report_test(2, "whole block", errors_before);
  endtask

  task automatic replacement_test();
    int errors_before;
    errors_before = error_count;
    check_miss_read(1'b1, block_address(6'd1, 5'd5, 3'd1)); // Tag A into way 0.
    check_hit_read(1'b1, block_address(6'd1, 5'd5, 3'd1));
    check_miss_read(1'b1, block_address(6'd2, 5'd5, 3'd2)); // Tag B into way 1.
    check_hit_read(1'b1, block_address(6'd2, 5'd5, 3'd2));
    check_hit_read(1'b1, block_address(6'd1, 5'd5, 3'd3));  // A is now most recent.
    check_miss_read(1'b1, block_address(6'd3, 5'd5, 3'd4)); // C evicts B.
    check_hit_read(1'b1, block_address(6'd3, 5'd5, 3'd4));
    check_hit_read(1'b1, block_address(6'd1, 5'd5, 3'd7));
    check_miss_read(1'b1, block_address(6'd2, 5'd5, 3'd2));
    report_test(3, "two-way replacement", errors_before);
  endtask

  task automatic contention_test();
    cache_pkg::address_t instruction_address;
    cache_pkg::address_t data_address;
    int                  errors_before;
    int                  cycles;
    int                  instruction_done;
    int                  data_done;
    errors_before       = error_count;
    instruction_address = block_address(6'd4, 5'd7, 3'd2);
    data_address        = block_address(6'd5, 5'd7, 3'd6);
    instruction_done    = -1;
    data_done           = -1;
    cycles              = 0;
    @(posedge clk);
    #2;
    drive_port(1'b0, 1'b1, instruction_address); // Both miss on the same edge.
    drive_port(1'b1, 1'b1, data_address);
    @(negedge clk);
    compare_hit("instruction_response", instruction_response, 1'b0);
    compare_hit("data_response", data_response, 1'b0);
    @(posedge clk);
    #2;
    drive_port(1'b0, 1'b0, instruction_address);
    drive_port(1'b1, 1'b0, data_address);
    while (((instruction_done < 0) || (data_done < 0)) && (cycles < BUSY_TIMEOUT)) begin
      @(negedge clk);
      cycles++;
      if ((data_done < 0) && !data_response.busy)
        data_done = cycles;
      if ((instruction_done < 0) && !instruction_response.busy)
        instruction_done = cycles;
    end
    if ((instruction_done < 0) || (data_done < 0)) begin
      error_count++;
      $display("a cache was still busy after %0d cycles of contention", BUSY_TIMEOUT);
    end else if (data_done >= instruction_done) begin
      error_count++;
      $display("data cache finished at cycle %0d, not before the instruction cache at %0d",
               data_done, instruction_done);
    end
    check_hit_read(1'b0, instruction_address);
    check_hit_read(1'b1, data_address);
    report_test(4, "shared memory contention", errors_before);
  endtask

  task automatic independence_test();
    int errors_before;
    errors_before = error_count;
    check_miss_read(1'b0, block_address(6'd6, 5'd9, 3'd0));
    check_hit_read(1'b0, block_address(6'd6, 5'd9, 3'd0));
    check_miss_read(1'b1, block_address(6'd6, 5'd9, 3'd0)); // Not shared with the data cache.
    report_test(5, "cache independence", errors_before);
  endtask

  initial begin
    reset               = 1'b1;
    instruction_request = '0;
    data_request        = '0;
    load_valid          = 1'b0;
    load_address        = 16'h0000;
    load_data           = 16'h0000;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;
    load_memory();
    cold_miss_test();
    whole_block_test();
    replacement_test();
    contention_test();
    independence_test();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- memory_subsystem.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/cache_fill_control.sv
rtl/cache_way_arrays.sv
rtl/cache_unit.sv
rtl/memory_arbiter.sv
rtl/main_memory.sv
rtl/memory_subsystem.sv
test/memory_subsystem_assertions.sv
test/memory_subsystem_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = memory_subsystem_tb
FILELIST  = memory_subsystem.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@result="$$(./obj_dir/V$(TOP))"; echo "$$result"; \
	echo "$$result" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
